/* src/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// Address and data widths
`define FETCH_ADDR_WIDTH 32
`define FETCH_BUS_WIDTH 64
`define FETCH_INSTR_WIDTH 32

// 4 KB pages, one-level table
`define FETCH_PAGE_BITS 12

// 8-entry direct-mapped TLB
`define FETCH_TLB_INDEX_BITS 3

// 16 lines of 4 bus words each
`define FETCH_LINE_WORDS 4
`define FETCH_CACHE_INDEX_BITS 4

`endif

/* src/mem_bus_pkg.sv */
package mem_bus_pkg;

  // Master currently holding the shared Wishbone port
  typedef enum logic [1:0] {
    OWNER_NONE,
    OWNER_TLB,
    OWNER_CACHE
  } bus_owner_t;

  // Phase of one master's read traffic
  typedef enum logic {
    BUS_IDLE,
    BUS_WAIT_ACK
  } bus_cycle_t;

endpackage

/* src/fetch_pkg.sv */
package fetch_pkg;

  typedef enum logic [1:0] {
    FETCH_TRANSLATE,  // Waiting on the TLB
    FETCH_READ,       // Waiting on the cache
    FETCH_HOLD        // Output parked for decode
  } fetch_state_t;

  typedef enum logic [1:0] {
    XLATE_LOOKUP,
    XLATE_WALK,
    XLATE_FILL
  } xlate_state_t;

  typedef enum logic [1:0] {
    FILL_LOOKUP,
    FILL_BUS,
    FILL_DONE
  } fill_state_t;

endpackage

/* src/itlb.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module itlb (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [`FETCH_ADDR_WIDTH-1:0] ptbr,
  input  logic                         xlate_req,
  input  logic [`FETCH_ADDR_WIDTH-1:0] vaddr,
  input  logic                         flush,
  input  logic                         wb_ack,
  input  logic [`FETCH_BUS_WIDTH-1:0]  wb_dat_i,
  output logic                         xlate_done,
  output logic                         xlate_fault,
  output logic [`FETCH_ADDR_WIDTH-1:0] paddr,
  output logic                         wb_cyc,
  output logic                         wb_stb,
  output logic [`FETCH_ADDR_WIDTH-1:0] wb_adr
);
  import fetch_pkg::*;
  import mem_bus_pkg::*;

  localparam int VPN_BITS = `FETCH_ADDR_WIDTH - `FETCH_PAGE_BITS;
  localparam int TAG_BITS = VPN_BITS - `FETCH_TLB_INDEX_BITS;
  localparam int ENTRIES = 1 << `FETCH_TLB_INDEX_BITS;

  logic [ENTRIES-1:0]  valid;
  logic [TAG_BITS-1:0] tag_mem [ENTRIES];
  logic [VPN_BITS-1:0] frame_mem [ENTRIES];

  xlate_state_t state;
  bus_cycle_t   bus_phase;

  logic [`FETCH_ADDR_WIDTH-1:0]    req_vaddr;  // Address under translation
  logic                            pte_valid;
  logic [VPN_BITS-1:0]             pte_frame;
  logic [VPN_BITS-1:0]             vpn;
  logic [VPN_BITS-1:0]             req_vpn;
  logic [`FETCH_TLB_INDEX_BITS-1:0] idx;
  logic [`FETCH_TLB_INDEX_BITS-1:0] req_idx;
  logic                            hit;

  assign vpn     = vaddr[`FETCH_ADDR_WIDTH-1:`FETCH_PAGE_BITS];
  assign idx     = vpn[`FETCH_TLB_INDEX_BITS-1:0];
  assign hit     = valid[idx] && (tag_mem[idx] == vpn[VPN_BITS-1:`FETCH_TLB_INDEX_BITS]);
  assign req_vpn = req_vaddr[`FETCH_ADDR_WIDTH-1:`FETCH_PAGE_BITS];
  assign req_idx = req_vpn[`FETCH_TLB_INDEX_BITS-1:0];

  // One 8-byte entry per virtual page
  assign wb_adr = ptbr + {{(`FETCH_ADDR_WIDTH-VPN_BITS-3){1'b0}}, req_vpn, 3'b000};
  assign wb_cyc = (bus_phase == BUS_WAIT_ACK);
  assign wb_stb = wb_cyc;

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= XLATE_LOOKUP;
      bus_phase   <= BUS_IDLE;
      valid       <= '0;
      xlate_done  <= 1'b0;
      xlate_fault <= 1'b0;
    end else begin
      xlate_done <= 1'b0;
      case (state)
        XLATE_LOOKUP: begin
          if (xlate_req && hit) begin
            xlate_done  <= 1'b1;
            xlate_fault <= 1'b0;
          end else if (xlate_req) begin
            state     <= XLATE_WALK;
            bus_phase <= BUS_WAIT_ACK;
          end
        end
        XLATE_WALK: begin
          if (wb_ack) begin
            state     <= XLATE_FILL;
            bus_phase <= BUS_IDLE;
          end
        end
        XLATE_FILL: begin
          if (pte_valid)
            valid[req_idx] <= 1'b1;
          xlate_done  <= 1'b1;
          xlate_fault <= !pte_valid;  // Invalid entry is never cached
          state       <= XLATE_LOOKUP;
        end
        default: state <= XLATE_LOOKUP;
      endcase
      if (flush)
        valid <= '0;
    end
  end

  // Entry arrays and translation result
  always_ff @(posedge clk) begin
    if (state == XLATE_LOOKUP && xlate_req) begin
      req_vaddr <= vaddr;
      paddr     <= {frame_mem[idx], vaddr[`FETCH_PAGE_BITS-1:0]};
    end
    if (state == XLATE_WALK && wb_ack) begin
      pte_valid <= wb_dat_i[0];
      pte_frame <= wb_dat_i[`FETCH_ADDR_WIDTH-1:`FETCH_PAGE_BITS];
    end
    if (state == XLATE_FILL) begin
      paddr <= {pte_frame, req_vaddr[`FETCH_PAGE_BITS-1:0]};
      if (pte_valid) begin
        tag_mem[req_idx]   <= req_vpn[VPN_BITS-1:`FETCH_TLB_INDEX_BITS];
        frame_mem[req_idx] <= pte_frame;
      end
    end
  end

endmodule

/* src/icache.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module icache (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          read_req,
  input  logic [`FETCH_ADDR_WIDTH-1:0]  read_addr,
  input  logic                          wb_ack,
  input  logic [`FETCH_BUS_WIDTH-1:0]   wb_dat_i,
  output logic                          read_done,
  output logic [`FETCH_INSTR_WIDTH-1:0] read_data,
  output logic                          wb_cyc,
  output logic                          wb_stb,
  output logic [`FETCH_ADDR_WIDTH-1:0]  wb_adr
);
  import fetch_pkg::*;
  import mem_bus_pkg::*;

  localparam int WORD_BITS = $clog2(`FETCH_LINE_WORDS);
  localparam int OFFSET_BITS = WORD_BITS + 3;
  localparam int IDX_HI = OFFSET_BITS + `FETCH_CACHE_INDEX_BITS;
  localparam int TAG_BITS = `FETCH_ADDR_WIDTH - IDX_HI;
  localparam int LINES = 1 << `FETCH_CACHE_INDEX_BITS;

  logic [LINES-1:0]            valid;
  logic [TAG_BITS-1:0]         tag_mem [LINES];
  logic [`FETCH_BUS_WIDTH-1:0] data_mem [LINES*`FETCH_LINE_WORDS];

  fill_state_t state;
  bus_cycle_t  bus_phase;

  logic [`FETCH_ADDR_WIDTH-1:0]      req_addr;
  logic [WORD_BITS-1:0]              fill_word;  // Next word of the line to read
  logic [`FETCH_CACHE_INDEX_BITS-1:0] idx;
  logic [`FETCH_CACHE_INDEX_BITS-1:0] req_idx;
  logic                              hit;

  function automatic logic [`FETCH_INSTR_WIDTH-1:0] pick_half(
    input logic [`FETCH_BUS_WIDTH-1:0] word,
    input logic                        upper
  );
    return upper ? word[`FETCH_BUS_WIDTH-1:`FETCH_INSTR_WIDTH]
                 : word[`FETCH_INSTR_WIDTH-1:0];
  endfunction

  assign idx     = read_addr[IDX_HI-1:OFFSET_BITS];
  assign req_idx = req_addr[IDX_HI-1:OFFSET_BITS];
  assign hit     = valid[idx] && (tag_mem[idx] == read_addr[`FETCH_ADDR_WIDTH-1:IDX_HI]);

  // Line fill walks the aligned line under one cycle
  assign wb_adr = {req_addr[`FETCH_ADDR_WIDTH-1:OFFSET_BITS], fill_word, 3'b000};
  assign wb_cyc = (bus_phase == BUS_WAIT_ACK);
  assign wb_stb = wb_cyc;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= FILL_LOOKUP;
      bus_phase <= BUS_IDLE;
      valid     <= '0;
      fill_word <= '0;
      read_done <= 1'b0;
    end else begin
      read_done <= 1'b0;
      case (state)
        FILL_LOOKUP: begin
          if (read_req && hit) begin
            read_done <= 1'b1;
          end else if (read_req) begin
            state     <= FILL_BUS;
            bus_phase <= BUS_WAIT_ACK;
            fill_word <= '0;
          end
        end
        FILL_BUS: begin
          if (wb_ack) begin
            fill_word <= fill_word + 1'b1;
            if (fill_word == WORD_BITS'(`FETCH_LINE_WORDS - 1)) begin
              state     <= FILL_DONE;
              bus_phase <= BUS_IDLE;
            end
          end
        end
        FILL_DONE: begin
          valid[req_idx] <= 1'b1;
          read_done      <= 1'b1;
          state          <= FILL_LOOKUP;
        end
        default: state <= FILL_LOOKUP;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == FILL_LOOKUP && read_req) begin
      req_addr  <= read_addr;
      read_data <= pick_half(data_mem[{idx, read_addr[OFFSET_BITS-1:3]}], read_addr[2]);
    end
    if (state == FILL_BUS && wb_ack)
      data_mem[{req_idx, fill_word}] <= wb_dat_i;
    if (state == FILL_DONE) begin
      tag_mem[req_idx] <= req_addr[`FETCH_ADDR_WIDTH-1:IDX_HI];
      read_data <= pick_half(data_mem[{req_idx, req_addr[OFFSET_BITS-1:3]}], req_addr[2]);
    end
  end

endmodule

/* src/bus_arbiter.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module bus_arbiter (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         tlb_cyc,
  input  logic                         tlb_stb,
  input  logic [`FETCH_ADDR_WIDTH-1:0] tlb_adr,
  input  logic                         cache_cyc,
  input  logic                         cache_stb,
  input  logic [`FETCH_ADDR_WIDTH-1:0] cache_adr,
  input  logic                         wb_ack,
  output logic                         tlb_ack,
  output logic                         cache_ack,
  output logic                         wb_cyc,
  output logic                         wb_stb,
  output logic                         wb_we,
  output logic [`FETCH_ADDR_WIDTH-1:0] wb_adr
);
  import mem_bus_pkg::*;

  bus_owner_t owner;
  bus_owner_t grant;

  always_comb begin
    if (owner == OWNER_TLB && tlb_cyc)
      grant = OWNER_TLB;      // Owner keeps the bus until it drops cyc
    else if (owner == OWNER_CACHE && cache_cyc)
      grant = OWNER_CACHE;
    else if (cache_cyc)
      grant = OWNER_CACHE;    // Cache wins a tie
    else if (tlb_cyc)
      grant = OWNER_TLB;
    else
      grant = OWNER_NONE;
  end

  always_ff @(posedge clk) begin
    if (reset)
      owner <= OWNER_NONE;
    else
      owner <= grant;
  end

  always_comb begin
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_adr = '0;
    case (grant)
      OWNER_TLB: begin
        wb_cyc = tlb_cyc;
        wb_stb = tlb_stb;
        wb_adr = tlb_adr;
      end
      OWNER_CACHE: begin
        wb_cyc = cache_cyc;
        wb_stb = cache_stb;
        wb_adr = cache_adr;
      end
      default: ;
    endcase
  end

  assign wb_we     = 1'b0;  // Fetch side only reads
  assign tlb_ack   = wb_ack && (grant == OWNER_TLB);
  assign cache_ack = wb_ack && (grant == OWNER_CACHE);

endmodule

/* src/fetch_stage.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_stage (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [`FETCH_ADDR_WIDTH-1:0]  entry_pc,
  input  logic                          ready,
  input  logic                          branch_taken,
  input  logic [`FETCH_ADDR_WIDTH-1:0]  branch_target,
  input  logic                          flush,
  input  logic [`FETCH_ADDR_WIDTH-1:0]  flush_pc,
  input  logic                          xlate_done,
  input  logic                          xlate_fault,
  input  logic [`FETCH_ADDR_WIDTH-1:0]  paddr,
  input  logic                          read_done,
  input  logic [`FETCH_INSTR_WIDTH-1:0] read_data,
  output logic                          xlate_req,
  output logic [`FETCH_ADDR_WIDTH-1:0]  vaddr,
  output logic                          read_req,
  output logic [`FETCH_ADDR_WIDTH-1:0]  read_addr,
  output logic                          instr_valid,
  output logic [`FETCH_INSTR_WIDTH-1:0] instr,
  output logic [`FETCH_ADDR_WIDTH-1:0]  pc,
  output logic                          fault
);
  import fetch_pkg::*;

  fetch_state_t state;

  logic [`FETCH_ADDR_WIDTH-1:0]  pc_q;
  logic                          issue;    // First cycle of a new translation
  logic                          discard;  // Result in flight belongs to an old PC
  logic                          out_valid;
  logic                          out_fault;
  logic [`FETCH_INSTR_WIDTH-1:0] out_instr;
  logic                          redirect;
  logic [`FETCH_ADDR_WIDTH-1:0]  redirect_pc;

  assign redirect    = flush || branch_taken;
  assign redirect_pc = flush ? flush_pc : branch_target;  // Flush first

  assign vaddr     = pc_q;
  assign xlate_req = (state == FETCH_TRANSLATE) && issue;
  assign read_req  = (state == FETCH_TRANSLATE) && xlate_done && !xlate_fault
                     && !discard && !redirect;
  assign read_addr = paddr;

  // A fresh cache result goes to decode in the cycle it arrives
  assign instr_valid = (state == FETCH_HOLD) ? out_valid
                                             : (state == FETCH_READ && read_done && !discard);
  assign instr = (state == FETCH_HOLD) ? out_instr : read_data;
  assign fault = (state == FETCH_HOLD) && out_valid && out_fault;
  assign pc    = pc_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= FETCH_TRANSLATE;
      pc_q      <= entry_pc;
      issue     <= 1'b1;
      discard   <= 1'b0;
      out_valid <= 1'b0;
      out_fault <= 1'b0;
    end else begin
      issue <= 1'b0;
      if (redirect)
        pc_q <= redirect_pc;
      case (state)
        FETCH_TRANSLATE: begin
          if (xlate_done) begin
            if (discard || redirect) begin
              issue   <= 1'b1;   // Restart at the new PC
              discard <= 1'b0;
            end else if (xlate_fault) begin
              state     <= FETCH_HOLD;
              out_valid <= 1'b1;
              out_fault <= 1'b1;
            end else begin
              state <= FETCH_READ;
            end
          end else if (redirect) begin
            discard <= 1'b1;
          end
        end
        FETCH_READ: begin
          if (read_done) begin
            state <= FETCH_TRANSLATE;
            issue <= 1'b1;
            if (discard || redirect) begin
              discard <= 1'b0;
            end else if (ready) begin
              pc_q <= pc_q + 4;
            end else begin
              state     <= FETCH_HOLD;   // Decode stalled
              issue     <= 1'b0;
              out_valid <= 1'b1;
              out_fault <= 1'b0;
            end
          end else if (redirect) begin
            discard <= 1'b1;
          end
        end
        FETCH_HOLD: begin
          if (redirect) begin
            state     <= FETCH_TRANSLATE;
            issue     <= 1'b1;
            out_valid <= 1'b0;
            out_fault <= 1'b0;
          end else if (out_valid && ready) begin
            out_valid <= 1'b0;
            // A fault stays parked here until a redirect
            if (!out_fault) begin
              state <= FETCH_TRANSLATE;
              issue <= 1'b1;
              pc_q  <= pc_q + 4;
            end
          end
        end
        default: state <= FETCH_TRANSLATE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == FETCH_READ && read_done)
      out_instr <= read_data;
  end

endmodule

/* src/fetch_top.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [`FETCH_ADDR_WIDTH-1:0]  entry_pc,
  input  logic [`FETCH_ADDR_WIDTH-1:0]  ptbr,
  input  logic                          ready,
  input  logic                          branch_taken,
  input  logic [`FETCH_ADDR_WIDTH-1:0]  branch_target,
  input  logic                          flush,
  input  logic [`FETCH_ADDR_WIDTH-1:0]  flush_pc,
  input  logic [`FETCH_BUS_WIDTH-1:0]   wb_dat_i,
  input  logic                          wb_ack,
  output logic                          instr_valid,
  output logic [`FETCH_INSTR_WIDTH-1:0] instr,
  output logic [`FETCH_ADDR_WIDTH-1:0]  pc,
  output logic                          fault,
  output logic                          wb_cyc,
  output logic                          wb_stb,
  output logic                          wb_we,
  output logic [`FETCH_ADDR_WIDTH-1:0]  wb_adr
);

  logic                          xlate_req;
  logic [`FETCH_ADDR_WIDTH-1:0]  vaddr;
  logic                          xlate_done;
  logic                          xlate_fault;
  logic [`FETCH_ADDR_WIDTH-1:0]  paddr;
  logic                          read_req;
  logic [`FETCH_ADDR_WIDTH-1:0]  read_addr;
  logic                          read_done;
  logic [`FETCH_INSTR_WIDTH-1:0] read_data;

  // Per-master Wishbone signals ahead of the arbiter
  logic                          tlb_cyc;
  logic                          tlb_stb;
  logic [`FETCH_ADDR_WIDTH-1:0]  tlb_adr;
  logic                          tlb_ack;
  logic                          cache_cyc;
  logic                          cache_stb;
  logic [`FETCH_ADDR_WIDTH-1:0]  cache_adr;
  logic                          cache_ack;

  fetch_stage u_stage (
    .clk           (clk),
    .reset         (reset),
    .entry_pc      (entry_pc),
    .ready         (ready),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .flush         (flush),
    .flush_pc      (flush_pc),
    .xlate_done    (xlate_done),
    .xlate_fault   (xlate_fault),
    .paddr         (paddr),
    .read_done     (read_done),
    .read_data     (read_data),
    .xlate_req     (xlate_req),
    .vaddr         (vaddr),
    .read_req      (read_req),
    .read_addr     (read_addr),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .pc            (pc),
    .fault         (fault)
  );

  itlb u_itlb (
    .clk         (clk),
    .reset       (reset),
    .ptbr        (ptbr),
    .xlate_req   (xlate_req),
    .vaddr       (vaddr),
    .flush       (flush),
    .wb_ack      (tlb_ack),
    .wb_dat_i    (wb_dat_i),   // Read data goes to both masters
    .xlate_done  (xlate_done),
    .xlate_fault (xlate_fault),
    .paddr       (paddr),
    .wb_cyc      (tlb_cyc),
    .wb_stb      (tlb_stb),
    .wb_adr      (tlb_adr)
  );

  icache u_icache (
    .clk       (clk),
    .reset     (reset),
    .read_req  (read_req),
    .read_addr (read_addr),
    .wb_ack    (cache_ack),
    .wb_dat_i  (wb_dat_i),
    .read_done (read_done),
    .read_data (read_data),
    .wb_cyc    (cache_cyc),
    .wb_stb    (cache_stb),
    .wb_adr    (cache_adr)
  );

  bus_arbiter u_arbiter (
    .clk       (clk),
    .reset     (reset),
    .tlb_cyc   (tlb_cyc),
    .tlb_stb   (tlb_stb),
    .tlb_adr   (tlb_adr),
    .cache_cyc (cache_cyc),
    .cache_stb (cache_stb),
    .cache_adr (cache_adr),
    .wb_ack    (wb_ack),
    .tlb_ack   (tlb_ack),
    .cache_ack (cache_ack),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr)
  );

endmodule

/* bench/mem_model.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module mem_model #(
  parameter logic [31:0] CODE_KEY = 32'h5A3C_96E1,
  parameter logic [31:0] PT_BASE  = 32'h0010_0000
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         cyc,
  input  logic                         stb,
  input  logic                         we,
  input  logic [`FETCH_ADDR_WIDTH-1:0] adr,
  output logic                         ack,
  output logic [`FETCH_BUS_WIDTH-1:0]  dat
);

  logic [`FETCH_BUS_WIDTH-1:0] pte [16];  // Loaded by the testbench
  integer wait_seed = 69188;
  logic        busy;
  logic [1:0]  wait_left;

  function automatic logic [`FETCH_BUS_WIDTH-1:0] read_word(input logic [31:0] a);
    logic [31:0] base;
    logic [31:0] off;
    base = {a[31:3], 3'b000};
    off  = base - PT_BASE;
    if (base >= PT_BASE && base < PT_BASE + 32'h1000) begin
      // Table slots past the mapped pages read as invalid
      if (off[31:3] < 16)
        return pte[off[6:3]];
      else
        return '0;
    end
    return {(base | 32'h4) ^ CODE_KEY, base ^ CODE_KEY};  // Low half is the lower address
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      ack       <= 1'b0;
      busy      <= 1'b0;
      wait_left <= '0;
      dat       <= '0;
    end else begin
      ack <= 1'b0;
      if (cyc && stb && !we && !ack) begin
        if (!busy) begin
          busy      <= 1'b1;
          wait_left <= 2'($random(wait_seed) & 3);
        end else if (wait_left == 0) begin
          ack  <= 1'b1;
          dat  <= read_word(adr);
          busy <= 1'b0;
        end else begin
          wait_left <= wait_left - 1'b1;
        end
      end
    end
  end

endmodule

/* bench/fetch_tb.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_tb;

  localparam logic [31:0] CODE_KEY = 32'h5A3C_96E1;
  localparam logic [31:0] PT_BASE  = 32'h0010_0000;
  localparam logic [31:0] ENTRY    = 32'h0000_0FF0;
  localparam int          BAD_VPN  = 9;
  localparam int          PLANNED  = 24 + 12 + 10 + 3 + 8 + 4 * 7;  // Instructions over all tests

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic [31:0] entry_pc = ENTRY;
  logic [31:0] ptbr = PT_BASE;
  logic ready = 1'b0;
  logic branch_taken = 1'b0;
  logic [31:0] branch_target = '0;
  logic flush = 1'b0;
  logic [31:0] flush_pc = '0;
  logic [63:0] wb_dat_i;
  logic wb_ack;
  logic instr_valid, fault, wb_cyc, wb_stb, wb_we;
  logic [31:0] instr, pc, wb_adr;

  integer seed = 69188;
  int map_frame [16];
  logic [31:0] exp_pc = ENTRY;
  logic halted = 1'b0;  // Fault taken, waiting for a redirect
  int accept_count = 0;
  int bus_cycles = 0;
  logic hold_prev = 1'b0;
  logic [31:0] hold_pc, hold_instr;

  always #20 clk = ~clk;

  fetch_top DUT (.*);

  mem_model #(.CODE_KEY(CODE_KEY), .PT_BASE(PT_BASE)) u_mem (
    .clk(clk), .reset(reset), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we),
    .adr(wb_adr), .ack(wb_ack), .dat(wb_dat_i)
  );

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s expected %h got %h", name, expected, actual);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  // Reference model of the fetch stream, sampled on every rising edge
  always @(posedge clk) begin
    logic [31:0] vpn;
    logic [31:0] phys;
    if (!reset) begin
      if (wb_cyc) begin
        bus_cycles++;
        check("wb_we", 0, wb_we);
      end
      if (wb_stb)
        check("wb_cyc", 1, wb_cyc);  // Strobe only inside a cycle
      if (hold_prev) begin
        check("instr_valid", 1, instr_valid);
        check("pc", hold_pc, pc);
        check("instr", hold_instr, instr);
      end
      hold_prev = instr_valid && !ready && !flush && !branch_taken;
      hold_pc = pc;
      hold_instr = instr;
      if (flush || branch_taken) begin
        exp_pc = flush ? flush_pc : branch_target;
        halted = 1'b0;
      end else if (instr_valid && ready) begin
        check("accept_after_fault", 0, halted);
        vpn = exp_pc >> `FETCH_PAGE_BITS;
        check("pc", exp_pc, pc);
        if (vpn >= 16 || vpn == BAD_VPN) begin
          check("fault", 1, fault);
          halted = 1'b1;
        end else begin
          phys = ((32'h20 + map_frame[vpn]) << `FETCH_PAGE_BITS) | (exp_pc & 32'hFFF);
          check("fault", 0, fault);
          check("instr", phys ^ CODE_KEY, instr);
          exp_pc = exp_pc + 4;
        end
        accept_count++;
      end
    end
  end

  task automatic run_accepts(input int n);
    int target;
    target = accept_count + n;
    while (accept_count < target) begin
      @(posedge clk);
      ready <= (($random(seed) & 3) != 0);
      @(negedge clk);
    end
  endtask

  task automatic redirect(input logic do_flush, input logic do_branch,
                          input logic [31:0] new_flush_pc, input logic [31:0] target);
    @(posedge clk);
    flush <= do_flush;
    branch_taken <= do_branch;
    flush_pc <= new_flush_pc;
    branch_target <= target;
    ready <= 1'b0;
    @(posedge clk);
    flush <= 1'b0;
    branch_taken <= 1'b0;
    @(negedge clk);
  endtask

  initial begin
    #(200 * PLANNED * 40);
    $display("Run timed out before all fetches completed");
    $display("Test failures found");
    $fatal(1);
  end

  initial begin
    int j;
    int tmp;
    int first;
    int start;
    for (int i = 0; i < 16; i++)
      map_frame[i] = i;
    for (int i = 15; i > 0; i--) begin  // Shuffle frames
      j = ($random(seed) & 32'h7FFF_FFFF) % (i + 1);
      tmp = map_frame[i];
      map_frame[i] = map_frame[j];
      map_frame[j] = tmp;
    end
    for (int i = 0; i < 16; i++)
      u_mem.pte[i] = (i == BAD_VPN) ? 64'h0 : 64'(((32'h20 + map_frame[i]) << 12) | 1);
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    run_accepts(24);                                 // Crosses a page and several lines
    redirect(1'b0, 1'b1, 32'h0, 32'h0000_3FF8);
    run_accepts(12);
    redirect(1'b1, 1'b1, 32'h0000_1040, 32'h0000_7000);  // Flush wins
    run_accepts(10);
    redirect(1'b0, 1'b1, 32'h0, 32'h0000_8FF8);
    while (!halted) begin
      @(posedge clk);
      ready <= 1'b1;
      @(negedge clk);
    end
    repeat (20) @(posedge clk);
    redirect(1'b0, 1'b1, 32'h0, 32'h0000_4000);
    run_accepts(8);
    redirect(1'b0, 1'b1, 32'h0, 32'h0000_C100);
    start = bus_cycles;
    run_accepts(7);
    first = bus_cycles - start;
    repeat (3) begin
      redirect(1'b0, 1'b1, 32'h0, 32'h0000_C100);
      start = bus_cycles;
      run_accepts(7);
      check("loop_bus_cycles_lower", 1, (bus_cycles - start) < first);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

/* fetch_unit.f */
+incdir+src
src/mem_bus_pkg.sv
src/fetch_pkg.sv
src/itlb.sv
src/icache.sv
src/bus_arbiter.sv
src/fetch_stage.sv
src/fetch_top.sv
bench/mem_model.sv
bench/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch unit testbench with Verilator

LOG=sim.log

verilator --binary --timing -Wno-fatal \
  -f fetch_unit.f \
  --top-module fetch_tb \
  --Mdir obj_dir \
  -o fetch_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi
